//--- hw/fetch_pkg.sv
package fetch_pkg;

    // geometry
    localparam int XLEN           = 32;
    localparam int BEAT_W         = 64;
    localparam int LINE_W         = 256;
    localparam int BEATS_PER_LINE = 4;
    localparam int BEAT_CNT_W     = 2;
    localparam int WORDS_PER_LINE = 8;
    localparam int NUM_SETS       = 16;
    localparam int TAG_W          = 23;
    localparam int IDX_W          = 4;
    localparam int WOFS_W         = 3;
    localparam int IQ_DEPTH       = 16;
    localparam int IQ_PTR_W       = 4;

    localparam logic [XLEN-1:0] RESET_PC = 32'h1eceb000;

    // tag | set | word in line | byte in word
    typedef struct packed {
        logic [TAG_W-1:0]  tag;
        logic [IDX_W-1:0]  idx;
        logic [WOFS_W-1:0] wofs;
        logic [1:0]        bofs;
    } fetch_addr_fields_t;

    typedef union packed {
        logic [XLEN-1:0]    raw;
        fetch_addr_fields_t f;
    } fetch_addr_u;

    typedef struct packed {
        logic        valid;
        fetch_addr_u addr;
    } fetch_req_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] inst;
    } fetch_resp_t;

    typedef struct packed {
        logic            read;
        logic [XLEN-1:0] addr;   // line aligned
    } bmem_req_t;

    typedef struct packed {
        logic              ready;
        logic [XLEN-1:0]   raddr;
        logic [BEAT_W-1:0] rdata;
        logic              rvalid;
    } bmem_resp_t;

    typedef struct packed {
        logic              valid;
        logic [LINE_W-1:0] data;
    } line_fill_t;

endpackage

//--- hw/cacheline_adapter.sv
module cacheline_adapter (
    input  logic                  clk,
    input  logic                  rst,
    input  fetch_pkg::bmem_resp_t bmem_resp_i,
    output fetch_pkg::line_fill_t line_fill_o
);
    import fetch_pkg::*;

    logic [LINE_W-1:0]     asm_q;        // beats collected so far
    logic [LINE_W-1:0]     asm_next;
    logic [BEAT_CNT_W-1:0] beat_cnt_q;
    logic                  last_beat;
    logic                  fill_valid_q;
    logic [LINE_W-1:0]     fill_data_q;

    // first beat ends up in the low 64 bits after four shifts
    assign asm_next  = {bmem_resp_i.rdata, asm_q[LINE_W-1:BEAT_W]};
    assign last_beat = bmem_resp_i.rvalid
                       && (beat_cnt_q == BEAT_CNT_W'(BEATS_PER_LINE - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt_q   <= '0;
            fill_valid_q <= 1'b0;
        end else begin
            fill_valid_q <= last_beat;   // one cycle pulse
            if (bmem_resp_i.rvalid) begin
                beat_cnt_q <= beat_cnt_q + 1'b1;   // wraps mod 4
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bmem_resp_i.rvalid) begin
            asm_q <= asm_next;
        end
        if (last_beat) begin
            fill_data_q <= asm_next;
        end
    end

    assign line_fill_o.valid = fill_valid_q;
    assign line_fill_o.data  = fill_data_q;

endmodule

//--- hw/icache.sv
module icache (
    input  logic                   clk,
    input  logic                   rst,
    input  fetch_pkg::fetch_req_t  req_i,
    output fetch_pkg::fetch_resp_t resp_o,
    output fetch_pkg::bmem_req_t   bmem_req_o,
    input  fetch_pkg::bmem_resp_t  bmem_resp_i,
    input  fetch_pkg::line_fill_t  line_fill_i
);
    import fetch_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,   // compare on incoming request
        S_REQ,    // line address out, waiting for ready
        S_WAIT    // beats in flight
    } state_e;

    state_e state_q;
    state_e state_d;

    logic [LINE_W-1:0]   data_q [NUM_SETS];
    logic [TAG_W-1:0]    tag_q  [NUM_SETS];
    logic [NUM_SETS-1:0] valid_q;

    fetch_addr_u       pend_q;       // missed address
    fetch_addr_u       line_addr;
    logic [LINE_W-1:0] hit_line;
    logic [XLEN-1:0]   hit_word;
    logic [XLEN-1:0]   fill_word;
    logic              hit;
    logic              lookup;
    logic              fill_done;
    logic              resp_valid_q;
    logic [XLEN-1:0]   resp_inst_q;

    assign lookup    = (state_q == S_IDLE) && req_i.valid;
    assign fill_done = (state_q == S_WAIT) && line_fill_i.valid;

    assign hit_line = data_q[req_i.addr.f.idx];
    assign hit      = valid_q[req_i.addr.f.idx]
                      && (tag_q[req_i.addr.f.idx] == req_i.addr.f.tag);
    assign hit_word = hit_line[req_i.addr.f.wofs * XLEN +: XLEN];

    // pending word straight out of the fill
    assign fill_word = line_fill_i.data[pend_q.f.wofs * XLEN +: XLEN];

    always_comb begin
        line_addr        = pend_q;
        line_addr.f.wofs = '0;
        line_addr.f.bofs = '0;
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (lookup && !hit) begin
                    state_d = S_REQ;
                end
            end
            S_REQ: begin
                if (bmem_resp_i.ready) begin
                    state_d = S_WAIT;
                end
            end
            S_WAIT: begin
                if (line_fill_i.valid) begin
                    state_d = S_IDLE;
                end
            end
            default: begin
                state_d = S_IDLE;
            end
        endcase
    end

    // strobe only in the accepting cycle
    assign bmem_req_o.read = (state_q == S_REQ) && bmem_resp_i.ready;
    assign bmem_req_o.addr = line_addr.raw;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q      <= S_IDLE;
            valid_q      <= '0;
            resp_valid_q <= 1'b0;
        end else begin
            state_q      <= state_d;
            resp_valid_q <= (lookup && hit) || fill_done;
            if (fill_done) begin
                valid_q[pend_q.f.idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lookup) begin
            pend_q <= req_i.addr;
        end
        if (lookup && hit) begin
            resp_inst_q <= hit_word;
        end
        if (fill_done) begin
            data_q[pend_q.f.idx] <= line_fill_i.data;
            tag_q[pend_q.f.idx]  <= pend_q.f.tag;
            resp_inst_q          <= fill_word;
        end
    end

    assign resp_o.valid = resp_valid_q;
    assign resp_o.inst  = resp_inst_q;

endmodule

//--- hw/inst_queue.sv
module inst_queue (
    input  logic                         clk,
    input  logic                         rst,
    input  fetch_pkg::fetch_resp_t       wr_i,
    input  logic [fetch_pkg::XLEN-1:0]   pc_i,
    output logic [fetch_pkg::XLEN-1:0]   data_o,
    output logic [fetch_pkg::XLEN-1:0]   pc_o,
    output logic                         valid_o,
    input  logic                         ready_i,
    output logic                         room_o
);
    import fetch_pkg::*;

    typedef struct packed {
        logic [XLEN-1:0] inst;
        logic [XLEN-1:0] pc;
    } iq_entry_t;

    iq_entry_t           mem_q [IQ_DEPTH];
    logic [IQ_PTR_W-1:0] wr_ptr_q;
    logic [IQ_PTR_W-1:0] rd_ptr_q;
    logic [IQ_PTR_W:0]   count_q;
    logic                push;
    logic                pop;

    assign valid_o = (count_q != '0);
    assign pop     = valid_o && ready_i;
    assign push    = wr_i.valid && (count_q != (IQ_PTR_W + 1)'(IQ_DEPTH));

    // keep two slots free for a fetch still in flight
    assign room_o = (count_q <= (IQ_PTR_W + 1)'(IQ_DEPTH - 2));

    assign data_o = mem_q[rd_ptr_q].inst;
    assign pc_o   = mem_q[rd_ptr_q].pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;   // pointers wrap at depth
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem_q[wr_ptr_q] <= '{inst: wr_i.inst, pc: pc_i};
        end
    end

endmodule

//--- hw/fetch_frontend.sv
module fetch_frontend (
    input  logic                        clk,
    input  logic                        rst,

    output fetch_pkg::bmem_req_t        bmem_req_o,
    input  fetch_pkg::bmem_resp_t       bmem_resp_i,

    output logic [fetch_pkg::XLEN-1:0]  inst_o,
    output logic [fetch_pkg::XLEN-1:0]  pc_o,
    output logic                        inst_valid_o,
    input  logic                        inst_ready_i
);
    import fetch_pkg::*;

    fetch_addr_u pc_q;
    fetch_addr_u inflight_addr_q;   // address of the fetch in the cache
    logic        inflight_q;
    logic        run_q;             // low for the first cycle out of reset
    logic        room;
    logic        issue;

    fetch_req_t  fetch_req;
    fetch_resp_t fetch_resp;
    line_fill_t  line_fill;

    // a response this cycle frees the slot for the next request
    assign issue = run_q && room && (!inflight_q || fetch_resp.valid);

    assign fetch_req.valid = issue;
    assign fetch_req.addr  = pc_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q.raw   <= RESET_PC;
            inflight_q <= 1'b0;
            run_q      <= 1'b0;
        end else begin
            run_q <= 1'b1;
            if (issue) begin
                pc_q.raw   <= pc_q.raw + XLEN'(4);
                inflight_q <= 1'b1;
            end else if (fetch_resp.valid) begin
                inflight_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            inflight_addr_q <= pc_q;
        end
    end

    icache i_icache (
        .clk         (clk),
        .rst         (rst),
        .req_i       (fetch_req),
        .resp_o      (fetch_resp),
        .bmem_req_o  (bmem_req_o),
        .bmem_resp_i (bmem_resp_i),
        .line_fill_i (line_fill)
    );

    cacheline_adapter i_adapter (
        .clk         (clk),
        .rst         (rst),
        .bmem_resp_i (bmem_resp_i),
        .line_fill_o (line_fill)
    );

    // response paired with its address on the way in
    inst_queue i_queue (
        .clk     (clk),
        .rst     (rst),
        .wr_i    (fetch_resp),
        .pc_i    (inflight_addr_q.raw),
        .data_o  (inst_o),
        .pc_o    (pc_o),
        .valid_o (inst_valid_o),
        .ready_i (inst_ready_i),
        .room_o  (room)
    );

endmodule

//--- dv/bmem_model.sv
module bmem_model (
    input  logic                  clk,
    input  logic                  rst,
    input  fetch_pkg::bmem_req_t  bmem_req_i,
    output fetch_pkg::bmem_resp_t bmem_resp_o
);
    timeunit 1ns;
    timeprecision 100ps;
    import fetch_pkg::*;

    localparam logic [XLEN-1:0] WORD_XOR = 32'ha5a5a5a5;

    logic [XLEN-1:0] line_addr;
    logic [XLEN-1:0] beat_addr;
    logic            accept;
    int unsigned     gap;

    // two words per beat with the lower address in the low half
    function automatic logic [BEAT_W-1:0] beat_data(input logic [XLEN-1:0] addr);
        return {(addr + XLEN'(4)) ^ WORD_XOR, addr ^ WORD_XOR};
    endfunction

    initial begin
        bmem_resp_o = '0;
        forever begin
            @(posedge clk);
            accept    = !rst && bmem_req_i.read && bmem_resp_o.ready;
            line_addr = bmem_req_i.addr;
            #10;
            if (rst) begin
                bmem_resp_o = '0;
            end else if (accept) begin
                bmem_resp_o.ready = 1'b0;   // one line at a time
                for (int b = 0; b < BEATS_PER_LINE; b++) begin
                    gap = $urandom_range(0, 5);
                    repeat (gap) begin
                        @(posedge clk);
                        #10;
                    end
                    beat_addr          = line_addr + XLEN'(8 * b);
                    bmem_resp_o.raddr  = beat_addr;
                    bmem_resp_o.rdata  = beat_data(beat_addr);
                    bmem_resp_o.rvalid = 1'b1;
                    @(posedge clk);
                    #10;
                    bmem_resp_o.rvalid = 1'b0;
                end
                bmem_resp_o.ready = ($urandom_range(0, 3) != 0);
            end else begin
                bmem_resp_o.ready = ($urandom_range(0, 3) != 0);   // random stalls
            end
        end
    end

endmodule

//--- dv/fetch_assertions.sv
module fetch_assertions (
    input logic                       clk,
    input logic                       rst,
    input fetch_pkg::bmem_req_t       bmem_req_i,
    input fetch_pkg::bmem_resp_t      bmem_resp_i,
    input logic [fetch_pkg::XLEN-1:0] inst_i,
    input logic [fetch_pkg::XLEN-1:0] pc_i,
    input logic                       inst_valid_i,
    input logic                       inst_ready_i
);
    timeunit 1ns;
    timeprecision 100ps;
    import fetch_pkg::*;

    logic [2:0] beats_due_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            beats_due_q <= '0;
        end else if (bmem_req_i.read) begin
            beats_due_q <= 3'(BEATS_PER_LINE);
        end else if (bmem_resp_i.rvalid && (beats_due_q != '0)) begin
            beats_due_q <= beats_due_q - 1'b1;
        end
    end

    read_one_cycle: assert property (@(posedge clk) disable iff (rst)
        bmem_req_i.read |=> !bmem_req_i.read)
        else $error("read strobe longer than one cycle");

    read_after_beats: assert property (@(posedge clk) disable iff (rst)
        bmem_req_i.read |-> (beats_due_q == '0))
        else $error("new read while beats of the last line are still due");

    out_hold: assert property (@(posedge clk) disable iff (rst)
        (inst_valid_i && !inst_ready_i)
        |=> (inst_valid_i && $stable(inst_i) && $stable(pc_i)))
        else $error("instruction output changed while stalled");

endmodule

//--- dv/fetch_tb.sv
module fetch_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import fetch_pkg::*;

    localparam int              NUM_INSTR  = 600;
    localparam int              MAX_CYCLES = NUM_INSTR * 40;
    localparam int              STALL_LEN  = 30;
    localparam int              NUM_STALLS = 3;
    localparam int              MAX_AHEAD  = 3;   // lines fetch may run past the consumer
    localparam logic [XLEN-1:0] WORD_XOR   = 32'ha5a5a5a5;

    logic            clk;
    logic            rst;
    bmem_req_t       bmem_req;
    bmem_resp_t      bmem_resp;
    logic [XLEN-1:0] inst;
    logic [XLEN-1:0] pc;
    logic            inst_valid;
    logic            inst_ready;

    fetch_addr_u     exp_pc;
    fetch_addr_u     exp_line;
    fetch_addr_u     held_pc;
    logic [XLEN-1:0] held_inst;
    logic            held;
    int              n_done;
    int              n_reads;
    int              n_lines;
    int              cycles;
    int              stall_left;
    int              stall_idx;
    int              stall_at [NUM_STALLS] = '{150, 300, 450};

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    fetch_frontend i_dut (
        .clk          (clk),
        .rst          (rst),
        .bmem_req_o   (bmem_req),
        .bmem_resp_i  (bmem_resp),
        .inst_o       (inst),
        .pc_o         (pc),
        .inst_valid_o (inst_valid),
        .inst_ready_i (inst_ready)
    );

    bmem_model i_mem (
        .clk         (clk),
        .rst         (rst),
        .bmem_req_i  (bmem_req),
        .bmem_resp_o (bmem_resp)
    );

    bind fetch_frontend fetch_assertions i_assertions (
        .clk          (clk),
        .rst          (rst),
        .bmem_req_i   (bmem_req_o),
        .bmem_resp_i  (bmem_resp_i),
        .inst_i       (inst_o),
        .pc_i         (pc_o),
        .inst_valid_i (inst_valid_o),
        .inst_ready_i (inst_ready_i)
    );

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1, "run stopped at cycle %0d", cycles);
    endtask

    task automatic check_word(input string name, input logic [XLEN-1:0] exp,
                              input logic [XLEN-1:0] act);
        if (act !== exp) begin
            abort_run($sformatf("ERR %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_addr(input string name, input fetch_addr_u exp,
                              input fetch_addr_u act);
        if (act.raw !== exp.raw) begin
            abort_run($sformatf("ERR %s expected %h actual %h", name, exp.raw, act.raw));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("ERR %s expected %b actual %b", name, exp, act));
        end
    endtask

    // random ready with long stalls once the stream reaches fixed points
    task automatic drive_consumer();
        if (stall_left == 0 && stall_idx < NUM_STALLS && n_done >= stall_at[stall_idx]) begin
            stall_left = STALL_LEN;
            stall_idx++;
        end
        if (stall_left > 0) begin
            inst_ready = 1'b0;
            stall_left--;
        end else begin
            inst_ready = ($urandom_range(0, 9) < 7);
        end
    endtask

    initial begin
        void'($urandom(44976));
        rst        = 1'b1;
        inst_ready = 1'b0;
        held       = 1'b0;
        held_inst  = '0;
        held_pc    = '0;
        exp_pc.raw = RESET_PC;
        n_done     = 0;
        n_reads    = 0;
        n_lines    = 0;
        cycles     = 0;
        stall_left = 0;
        stall_idx  = 0;

        for (int i = 0; i < 5; i++) begin
            @(posedge clk);
            if (i > 0) begin   // regs are unknown before the first reset edge
                check_flag("reset read strobe", 1'b0, bmem_req.read);
                check_flag("reset inst valid", 1'b0, inst_valid);
            end
            if (i == 3) begin
                #10;
                rst = 1'b0;
            end
        end

        while (n_done < NUM_INSTR) begin
            #10;
            drive_consumer();
            @(posedge clk);
            cycles++;
            if (cycles > MAX_CYCLES) begin
                abort_run($sformatf("timeout after %0d cycles, %0d of %0d instructions seen",
                                    cycles, n_done, NUM_INSTR));
            end
            if (bmem_req.read && bmem_resp.ready) begin
                exp_line.raw    = RESET_PC + XLEN'(n_reads * 32);
                exp_line.f.wofs = '0;
                exp_line.f.bofs = '0;
                check_addr("line read address", exp_line, fetch_addr_u'(bmem_req.addr));
                n_reads++;
            end
            if (held) begin
                check_flag("stall valid", 1'b1, inst_valid);
                check_word("stall inst", held_inst, inst);
                check_addr("stall pc", held_pc, fetch_addr_u'(pc));
            end
            if (inst_valid && inst_ready) begin
                check_addr("fetch order", exp_pc, fetch_addr_u'(pc));
                check_word("inst word", exp_pc.raw ^ WORD_XOR, inst);
                if (exp_pc.f.wofs == '0) begin
                    n_lines++;
                    if (n_reads < n_lines) begin
                        abort_run("a line was delivered before memory returned it");
                    end
                end
                exp_pc.raw = exp_pc.raw + XLEN'(4);
                n_done++;
            end
            held      = inst_valid && !inst_ready;
            held_inst = inst;
            held_pc   = pc;
        end

        if (n_reads < n_lines || n_reads > n_lines + MAX_AHEAD) begin
            abort_run($sformatf("%0d line reads for %0d delivered lines", n_reads, n_lines));
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

//--- vlog.f
hw/fetch_pkg.sv
hw/cacheline_adapter.sv
hw/icache.sv
hw/inst_queue.sv
hw/fetch_frontend.sv
dv/bmem_model.sv
dv/fetch_assertions.sv
dv/fetch_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/100ps -j 0
TOP      = fetch_tb
FILELIST = vlog.f
OBJ_DIR  = obj_dir
LOG      = sim.log

SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG) || ! grep -q "Simulation PASSED" $(LOG); then \
		echo "run failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
